// ==== list.f ====
+incdir+hdl
hdl/synth_pkg.sv
hdl/synth_ifs.sv
hdl/midi_rx.sv
hdl/voice_bank.sv
hdl/mode_ctrl.sv
hdl/voice_mixer.sv
hdl/poly_synth.sv
testbench/tb_poly_synth.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the poly_synth testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module tb_poly_synth -Mdir obj_dir

out=$(./obj_dir/Vtb_poly_synth)
echo "$out"

# Pass only when the testbench reports it
echo "$out" | grep -q "Regression passed"

// ==== testbench/tb_poly_synth.sv ====
/*
 * Testbench for poly_synth with MIDI bytes sent on ser_in at 320 clocks per bit
 * Square-mode samples are checked against every sign combination of the voices
 * Wave mode is inferred from the samples since the DUT does not export it
 */
`timescale 1ns/1ps
`include "synth_defs.svh"

module tb_poly_synth;
	import synth_pkg::*;

	typedef logic [11:0] sample_q_t[$];

	logic        MHz10;
	logic        nrst;
	logic        en;
	logic        ser_in;
	logic        clear;
	logic        wave_pb;
	logic [11:0] dac_out;
	logic        sample_strobe;

	sample_q_t   allowed;     // Values the compare process accepts
	sample_q_t   history;     // Samples since the last delete
	logic [11:0] last_sample;
	bit          check_on;
	int          n_samples;
	int          n_checked;
	int          n_value_err;
	int          n_other_err;
	int          n1, n2, v1, v2, a1, k, count;
	int          vels[$];
	bit          seen_lo, seen_hi;

	poly_synth u_dut (
		.MHz10         (MHz10),
		.nrst          (nrst),
		.en            (en),
		.ser_in        (ser_in),
		.clear         (clear),
		.wave_pb       (wave_pb),
		.dac_out       (dac_out),
		.sample_strobe (sample_strobe)
	);

	initial begin
		MHz10 = 1'b0;
		forever #50 MHz10 = ~MHz10;
	end

	// Each voice adds +a or -a with a = floor(127 * v / 64)
	function automatic sample_q_t square_set(input int vs[$]);
		sample_q_t vals;
		int        sum;
		for (int m = 0; m < (1 << vs.size()); m++) begin
			sum = 2048;
			foreach (vs[i])
				sum += m[i] ? (127 * vs[i]) / 64 : -((127 * vs[i]) / 64);
			vals.push_back(12'(sum));
		end
		return vals;
	endfunction

	function automatic sample_q_t range_set(input int lo, input int hi);
		sample_q_t vals;
		for (int x = lo; x <= hi; x++)
			vals.push_back(12'(x));
		return vals;
	endfunction

	// Closest accepted value (got itself when it is accepted)
	function automatic logic [11:0] nearest_allowed(input logic [11:0] got);
		logic [11:0] best;
		int          d;
		int          best_d;
		best   = got;
		best_d = 1 << 20;
		foreach (allowed[i]) begin
			d = int'(allowed[i]) - int'(got);
			if (d < 0)
				d = -d;
			if (d < best_d) begin
				best_d = d;
				best   = allowed[i];
			end
		end
		return best;
	endfunction

	// Two levels is square, a big jump is the saw wrap, else triangle
	function automatic wave_mode_t infer_mode(input logic [11:0] s[$]);
		logic [11:0] first;
		logic [11:0] other;
		int          n_distinct;
		int          max_step;
		int          step;
		first      = '0;
		other      = '0;
		n_distinct = 0;
		max_step   = 0;
		foreach (s[i]) begin
			if (n_distinct == 0) begin
				first      = s[i];
				n_distinct = 1;
			end else if (n_distinct == 1 && s[i] != first) begin
				other      = s[i];
				n_distinct = 2;
			end else if (s[i] != first && s[i] != other)
				n_distinct = 3;
			if (i > 0) begin
				step = int'(s[i]) - int'(s[i-1]);
				if (step < 0)
					step = -step;
				if (step > max_step)
					max_step = step;
			end
		end
		if (n_distinct <= 2)
			return wave_square;
		else if (max_step > 128)
			return wave_saw;
		else
			return wave_tri;
	endfunction

	task automatic check_sample(input logic [11:0] exp, input logic [11:0] got);
		if (got !== exp) begin
			$display("[FAIL] %0t dac_out expected %0d got %0d", $time, exp, got);
			n_value_err++;
		end
	endtask

	task automatic check_mode(input wave_mode_t exp, input wave_mode_t got);
		if (got !== exp) begin
			$display("[FAIL] %0t wave_mode expected %s got %s",
				$time, exp.name(), got.name());
			n_value_err++;
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step_clock();
		@(posedge MHz10);
		#1;
	endtask

	task automatic send_byte(input logic [7:0] b);
		ser_in = 1'b0;  // Start bit
		repeat (`SYNTH_BAUD_DIV) step_clock();
		for (int i = 0; i < 8; i++) begin
			ser_in = b[i];
			repeat (`SYNTH_BAUD_DIV) step_clock();
		end
		ser_in = 1'b1;
		repeat (`SYNTH_BAUD_DIV) step_clock();
	endtask

	task automatic send_msg(input logic [7:0] st, input int d1, input int d2);
		send_byte(st);
		send_byte(8'(d1));
		send_byte(8'(d2));
	endtask

	task automatic wait_strobes(input int n);
		int target;
		int cycles;
		target = n_samples + n;
		cycles = 0;
		while (n_samples < target && cycles < n * 2 * `SYNTH_SAMPLE_DIV + 100) begin
			step_clock();
			cycles++;
		end
		if (n_samples < target) begin
			$display("Timeout at %0t, sample_strobe did not pulse %0d times", $time, n);
			n_other_err++;
		end
	endtask

	task automatic press_button();
		wave_pb = 1'b1;
		repeat (`SYNTH_DEBOUNCE + 100) step_clock();
		wave_pb = 1'b0;
		repeat (`SYNTH_DEBOUNCE + 100) step_clock();
	endtask

	// Settle, then let the compare process check n strobes
	task automatic checked_run(input sample_q_t vals, input int n);
		wait_strobes(2);
		allowed = vals;
		history.delete();
		check_on = 1'b1;
		wait_strobes(n);
		check_on = 1'b0;
	endtask

	task automatic expect_silence();
		wait_strobes(2);
		check_sample(12'd2048, last_sample);
	endtask

	// Compare process samples dac_out at the falling edge where it is stable
	always @(negedge MHz10) begin
		if (nrst && sample_strobe) begin
			n_samples++;
			last_sample = dac_out;
			history.push_back(dac_out);
			if (check_on) begin
				n_checked++;
				check_sample(nearest_allowed(dac_out), dac_out);
			end
		end
	end

	initial begin
		$timeformat(-9, 0, " ns", 0);
		nrst     = 1'b0;
		en       = 1'b1;
		ser_in   = 1'b1;
		clear    = 1'b0;
		wave_pb  = 1'b0;
		check_on = 1'b0;
		void'($urandom(32'he15f_a8f6));
		repeat (10) @(posedge MHz10);
		#1;
		nrst = 1'b1;

		checked_run(range_set(2048, 2048), 20);  // Idle output

		// One note in square mode
		press_button();
		n1 = 48 + $urandom % 24;
		v1 = 32 + $urandom % 96;
		a1 = (127 * v1) / 64;
		send_msg(8'h90, n1, v1);
		vels = '{v1};
		wait_strobes(2);
		allowed = square_set(vels);
		history.delete();
		check_on = 1'b1;
		seen_lo  = 1'b0;
		seen_hi  = 1'b0;
		k        = 0;
		while (!(seen_lo && seen_hi) && k < 2000) begin
			wait_strobes(1);
			k++;
			if (last_sample == 12'(2048 - a1))
				seen_lo = 1'b1;
			if (last_sample == 12'(2048 + a1))
				seen_hi = 1'b1;
		end
		check_on = 1'b0;
		if (!(seen_lo && seen_hi)) begin
			$display("Both square levels of one note did not appear within 2000 samples");
			n_other_err++;
		end
		check_mode(wave_square, infer_mode(history));
		send_msg(8'h80, n1, 64);
		expect_silence();

		// Two notes released by Note Off and by velocity 0
		n1 = 48 + $urandom % 12;
		n2 = 60 + $urandom % 12;
		v1 = 1 + $urandom % 127;
		v2 = 1 + $urandom % 127;
		send_msg(8'h90, n1, v1);
		send_msg(8'h91, n2, v2);
		vels = '{v1, v2};
		checked_run(square_set(vels), 300);
		send_msg(8'h80, n1, 64);
		send_msg(8'h91, n2, 0);
		expect_silence();

		// Sustain keeps a released note sounding
		send_msg(8'hB0, 64, 127);
		send_msg(8'h90, n1, v1);
		send_msg(8'h80, n1, 64);
		vels = '{v1};
		checked_run(square_set(vels), 200);
		send_msg(8'hB0, 64, 0);
		expect_silence();

		// Nine notes on eight voices
		vels.delete();
		for (int i = 0; i < 9; i++) begin
			v2 = 1 + $urandom % 127;
			if (i < 8)
				vels.push_back(v2);
			send_msg(8'h90, 36 + 6 * i + $urandom % 6, v2);
		end
		checked_run(square_set(vels), 300);
		clear = 1'b1;
		step_clock();
		clear = 1'b0;
		wait_strobes(1);
		check_sample(12'd2048, last_sample);

		// Saw, then triangle, at velocity 64
		press_button();
		press_button();
		send_msg(8'h90, 60, 64);
		checked_run(range_set(1920, 2176), 400);
		check_mode(wave_saw, infer_mode(history));
		send_msg(8'h80, 60, 64);
		expect_silence();
		press_button();
		press_button();
		send_msg(8'h90, 60, 64);
		checked_run(range_set(1920, 2176), 400);
		check_mode(wave_tri, infer_mode(history));
		send_msg(8'h80, 60, 64);
		expect_silence();

		// en low right after a strobe freezes the sample clock
		wait_strobes(1);
		en    = 1'b0;
		count = n_samples;
		repeat (1000) step_clock();
		if (n_samples != count) begin
			$display("sample_strobe pulsed %0d times while en was low", n_samples - count);
			n_other_err++;
		end
		en = 1'b1;
		wait_strobes(2);

		$display("Errors: %0d wrong values, %0d other failures, %0d samples checked",
			n_value_err, n_other_err, n_checked);
		if (n_value_err == 0 && n_other_err == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== hdl/poly_synth.sv ====
/*
 * Polyphonic MIDI synth core, 10 MHz clock
 * ser_in idles high, wave_pb is active high, clear empties all voices
 * dac_out is a 12-bit offset binary sample, new value on each sample_strobe
 */
`timescale 1ns/1ps

module poly_synth (
	input  logic        MHz10,
	input  logic        nrst,
	input  logic        en,
	input  logic        ser_in,
	input  logic        clear,
	input  logic        wave_pb,
	output logic [11:0] dac_out,
	output logic        sample_strobe
);
	import synth_pkg::*;

	wave_mode_t wave_mode;
	logic       sustain;
	logic       sample_tick;

	midi_ev_if ev_bus ();
	voice_if   voice_bus ();

	midi_rx u_midi_rx (
		.MHz10  (MHz10),
		.nrst   (nrst),
		.en     (en),
		.ser_in (ser_in),
		.ev     (ev_bus.source)
	);

	voice_bank u_voice_bank (
		.MHz10       (MHz10),
		.nrst        (nrst),
		.en          (en),
		.clear       (clear),
		.sustain     (sustain),
		.sample_tick (sample_tick),
		.ev          (ev_bus.sink),
		.vp          (voice_bus.bank)
	);

	mode_ctrl u_mode_ctrl (
		.MHz10     (MHz10),
		.nrst      (nrst),
		.en        (en),
		.wave_pb   (wave_pb),
		.ev        (ev_bus.sink),
		.wave_mode (wave_mode),
		.sustain   (sustain)
	);

	voice_mixer u_voice_mixer (
		.MHz10         (MHz10),
		.nrst          (nrst),
		.en            (en),
		.clear         (clear),
		.wave_mode     (wave_mode),
		.vp            (voice_bus.mixer),
		.sample_tick   (sample_tick),
		.dac_out       (dac_out),
		.sample_strobe (sample_strobe)
	);

endmodule

// ==== hdl/voice_mixer.sv ====
/*
 * Sample clock, voice scan and DAC latch
 * Each sample reads voices 0 to 7 over eight cycles and dac_out updates ten cycles
 * after sample_tick
 * Output is offset binary with 2048 as silence
 */
`timescale 1ns/1ps
`include "synth_defs.svh"

module voice_mixer (
	input  logic                  MHz10,
	input  logic                  nrst,
	input  logic                  en,
	input  logic                  clear,
	input  synth_pkg::wave_mode_t wave_mode,
	voice_if.mixer                vp,
	output logic                  sample_tick,
	output logic [11:0]           dac_out,
	output logic                  sample_strobe
);
	import synth_pkg::*;

	localparam int div_w = $clog2(`SYNTH_SAMPLE_DIV);

	logic [div_w-1:0]   div_cnt;
	logic               busy;     // Scan in progress
	logic               done_p;   // Sum complete and latched next cycle
	voice_idx_t         sel_r;
	logic signed [13:0] acc;

	logic [7:0]         p;
	logic [7:0]         fold;
	logic signed [8:0]  shaped;
	logic [7:0]         mag;
	logic [14:0]        prod;
	logic signed [9:0]  term;
	logic signed [14:0] biased;
	logic [11:0]        clipped;

	assign vp.sel = sel_r;

	// Wave shaping and velocity scaling of the selected voice
	always_comb begin
		p    = vp.phase[`SYNTH_PHASE_W-1 -: 8];
		fold = {p[7] ? ~p[6:0] : p[6:0], 1'b0};  // Triangle rises then falls
		case (wave_mode)
			wave_square: shaped = p[7] ? 9'sd127 : -9'sd127;
			wave_tri:    shaped = $signed({1'b0, fold}) - 9'sd128;
			default:     shaped = $signed({1'b0, p}) - 9'sd128;
		endcase
		// Scale the magnitude so both square levels are the same size
		mag  = shaped[8] ? 8'(-shaped) : shaped[7:0];
		prod = mag * vp.vel;
		if (!vp.active)
			term = '0;
		else if (shaped[8])
			term = -$signed({1'b0, prod[14:6]});
		else
			term = $signed({1'b0, prod[14:6]});
	end

	always_comb begin
		biased = acc + 15'sd2048;
		if (biased < 0)
			clipped = 12'd0;
		else if (biased > 15'sd4095)
			clipped = 12'd4095;
		else
			clipped = biased[11:0];
	end

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			div_cnt       <= '0;
			sample_tick   <= 1'b0;
			busy          <= 1'b0;
			done_p        <= 1'b0;
			sel_r         <= '0;
			acc           <= '0;
			dac_out       <= 12'd2048;
			sample_strobe <= 1'b0;
		end else if (en) begin
			sample_tick   <= 1'b0;
			sample_strobe <= 1'b0;
			done_p        <= 1'b0;

			if (div_cnt == div_w'(`SYNTH_SAMPLE_DIV - 1)) begin
				div_cnt     <= '0;
				sample_tick <= 1'b1;
			end else
				div_cnt <= div_cnt + 1'b1;

			if (sample_tick) begin
				busy  <= 1'b1;
				sel_r <= '0;
				acc   <= '0;
			end else if (busy) begin
				acc <= acc + term;
				if (sel_r == voice_idx_t'(`SYNTH_VOICES - 1)) begin
					busy   <= 1'b0;
					done_p <= 1'b1;
				end else
					sel_r <= sel_r + 1'b1;
			end

			if (done_p) begin
				dac_out       <= clipped;
				sample_strobe <= 1'b1;
			end

			// Voices empty this cycle too, so the rest of the scan adds zero
			if (clear) begin
				acc     <= '0;
				dac_out <= 12'd2048;
			end
		end
	end

	// A new sample tick never lands in a running scan
	a_scan_fits: assert property (@(posedge MHz10) disable iff (!nrst)
		sample_tick |-> !busy);

endmodule

// ==== hdl/mode_ctrl.sv ====
/*
 * Wave mode button and sustain pedal
 * The button is active high and must be stable for SYNTH_DEBOUNCE clocks
 */
`timescale 1ns/1ps
`include "synth_defs.svh"

module mode_ctrl (
	input  logic                    MHz10,
	input  logic                    nrst,
	input  logic                    en,
	input  logic                    wave_pb,
	midi_ev_if.sink                 ev,
	output synth_pkg::wave_mode_t   wave_mode,
	output logic                    sustain
);
	import synth_pkg::*;

	localparam int deb_w = $clog2(`SYNTH_DEBOUNCE);

	logic             pb_meta, pb_sync;
	logic             pb_stable;  // Debounced button level
	logic [deb_w-1:0] deb_cnt;
	wave_mode_t       mode_next;

	always_comb begin
		case (wave_mode)
			wave_saw:    mode_next = wave_square;
			wave_square: mode_next = wave_tri;
			default:     mode_next = wave_saw;
		endcase
	end

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			pb_meta   <= 1'b0;
			pb_sync   <= 1'b0;
			pb_stable <= 1'b0;
			deb_cnt   <= '0;
			wave_mode <= wave_saw;
			sustain   <= 1'b0;
		end else if (en) begin
			pb_meta <= wave_pb;
			pb_sync <= pb_meta;
			if (pb_sync == pb_stable)
				deb_cnt <= '0;  // Bounce restarts the wait
			else if (deb_cnt == deb_w'(`SYNTH_DEBOUNCE - 1)) begin
				deb_cnt   <= '0;
				pb_stable <= pb_sync;
				if (pb_sync)
					wave_mode <= mode_next;  // Advance on press, not release
			end else
				deb_cnt <= deb_cnt + 1'b1;

			// Controller 64 is the damper pedal
			if (ev.valid && ev.kind == kind_control && ev.note == 7'd64)
				sustain <= (ev.value >= 7'd64);
		end
	end

endmodule

// ==== hdl/voice_bank.sv ====
/*
 * Voice state and phase accumulators
 * A Note On with no free voice is dropped, a Note Off frees every voice on that note
 * Pitch uses a 12 entry table for the top octave, shifted down per octave
 */
`timescale 1ns/1ps
`include "synth_defs.svh"

module voice_bank (
	input  logic    MHz10,
	input  logic    nrst,
	input  logic    en,
	input  logic    clear,
	input  logic    sustain,
	input  logic    sample_tick,
	midi_ev_if.sink ev,
	voice_if.bank   vp
);
	import synth_pkg::*;

	localparam int nv = `SYNTH_VOICES;

	logic [nv-1:0] active;
	logic [nv-1:0] held;    // Released while the pedal was down
	logic          sustain_q;
	note_t         note_r  [nv];
	vel_t          vel_r   [nv];
	phase_t        inc_r   [nv];
	phase_t        phase_r [nv];

	logic          note_on_ev, note_off_ev, sus_fall;
	logic          free_found;
	voice_idx_t    free_idx;

	// Phase step per sample at 40 kHz
	function automatic phase_t note_inc(input note_t n);
		logic [3:0] octave;
		logic [3:0] semi;
		phase_t     base;
		octave = 4'(n / 7'd12);
		semi   = 4'(n % 7'd12);
		case (semi)  // Notes 120 to 131
			4'd0:    base = 20'd219467;
			4'd1:    base = 20'd232518;
			4'd2:    base = 20'd246344;
			4'd3:    base = 20'd260993;
			4'd4:    base = 20'd276512;
			4'd5:    base = 20'd292954;
			4'd6:    base = 20'd310374;
			4'd7:    base = 20'd328830;
			4'd8:    base = 20'd348383;
			4'd9:    base = 20'd369099;
			4'd10:   base = 20'd391046;
			default: base = 20'd414300;
		endcase
		return base >> (4'd10 - octave);
	endfunction

	assign note_on_ev  = ev.valid && (ev.kind == kind_note_on);
	assign note_off_ev = ev.valid && (ev.kind == kind_note_off);
	assign sus_fall    = sustain_q && !sustain;

	// Lowest inactive voice
	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		for (int i = nv - 1; i >= 0; i--) begin
			if (!active[i]) begin
				free_found = 1'b1;
				free_idx   = voice_idx_t'(i);
			end
		end
	end

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			active    <= '0;
			held      <= '0;
			sustain_q <= 1'b0;
		end else if (en) begin
			sustain_q <= sustain;
			if (clear) begin
				active <= '0;
				held   <= '0;
			end else begin
				for (int i = 0; i < nv; i++) begin
					if (sus_fall && held[i]) begin
						active[i] <= 1'b0;
						held[i]   <= 1'b0;
					end
					if (note_off_ev && active[i] && note_r[i] == ev.note) begin
						if (sustain)
							held[i] <= 1'b1;
						else begin
							active[i] <= 1'b0;
							held[i]   <= 1'b0;
						end
					end
				end
				if (note_on_ev && free_found)
					active[free_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge MHz10) begin
		if (en) begin
			if (sample_tick) begin
				for (int i = 0; i < nv; i++)
					if (active[i])
						phase_r[i] <= phase_r[i] + inc_r[i];
			end
			if (note_on_ev && free_found && !clear) begin
				note_r[free_idx]  <= ev.note;
				vel_r[free_idx]   <= ev.value;
				inc_r[free_idx]   <= note_inc(ev.note);
				phase_r[free_idx] <= '0;  // New note starts at phase zero
			end
		end
	end

	assign vp.active = active[vp.sel];
	assign vp.phase  = phase_r[vp.sel];
	assign vp.vel    = vel_r[vp.sel];

	a_held_active: assert property (@(posedge MHz10) disable iff (!nrst)
		(held & ~active) == '0);

endmodule

// ==== hdl/midi_rx.sv ====
/*
 * MIDI serial receiver and parser, 8N1 at SYNTH_BAUD_DIV clocks per bit
 * Only Note On, Note Off and controller messages produce events
 * Running status is not supported, every message needs its status byte
 */
`timescale 1ns/1ps
`include "synth_defs.svh"

module midi_rx (
	input  logic      MHz10,
	input  logic      nrst,
	input  logic      en,
	input  logic      ser_in,
	midi_ev_if.source ev
);
	import synth_pkg::*;

	localparam int baud_w = $clog2(`SYNTH_BAUD_DIV);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;
	typedef enum logic [1:0] {p_status, p_data1, p_data2} p_state_t;

	logic              rx_meta, rx_sync;
	rx_state_t         rx_state;
	logic [baud_w-1:0] baud_cnt;
	logic [2:0]        bit_cnt;
	midi_byte_t        rx_byte;
	logic              byte_rdy;  // One cycle after the stop-bit sample

	p_state_t          p_state;
	logic [3:0]        status_hi;
	note_t             data1;
	logic              msg_done;

	// Byte receiver
	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			rx_meta  <= 1'b1;
			rx_sync  <= 1'b1;
			rx_state <= rx_idle;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			rx_byte  <= '0;
			byte_rdy <= 1'b0;
		end else if (en) begin
			rx_meta  <= ser_in;
			rx_sync  <= rx_meta;
			byte_rdy <= 1'b0;
			case (rx_state)
				rx_idle: begin
					baud_cnt <= '0;
					if (!rx_sync)
						rx_state <= rx_start;
				end
				rx_start: begin
					// Half a bit in, check that the start bit is still low
					if (baud_cnt == baud_w'(`SYNTH_BAUD_DIV / 2 - 1)) begin
						baud_cnt <= '0;
						bit_cnt  <= '0;
						rx_state <= rx_sync ? rx_idle : rx_data;
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
				rx_data: begin
					if (baud_cnt == baud_w'(`SYNTH_BAUD_DIV - 1)) begin
						baud_cnt <= '0;
						rx_byte  <= {rx_sync, rx_byte[7:1]};  // LSB first
						if (bit_cnt == 3'd7)
							rx_state <= rx_stop;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
				default: begin
					if (baud_cnt == baud_w'(`SYNTH_BAUD_DIV - 1)) begin
						byte_rdy <= rx_sync;  // Framing error drops the byte
						rx_state <= rx_idle;
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
			endcase
		end
	end

	assign msg_done = byte_rdy && !rx_byte[7] && (p_state == p_data2);

	// Message parser
	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			p_state   <= p_status;
			status_hi <= '0;
			data1     <= '0;
			ev.valid  <= 1'b0;
		end else if (en) begin
			ev.valid <= msg_done;
			if (byte_rdy) begin
				if (rx_byte[7]) begin
					status_hi <= rx_byte[7:4];
					if (rx_byte[7:4] inside {4'h8, 4'h9, 4'hB})
						p_state <= p_data1;
					else
						p_state <= p_status;  // Other status bytes end the message
				end else if (p_state == p_data1) begin
					data1   <= rx_byte[6:0];
					p_state <= p_data2;
				end else
					p_state <= p_status;
			end
		end
	end

	// Event payload, held until the next event
	always_ff @(posedge MHz10) begin
		if (en && msg_done) begin
			ev.note  <= data1;
			ev.value <= rx_byte[6:0];
			if (status_hi == 4'hB)
				ev.kind <= kind_control;
			else if (status_hi == 4'h9 && rx_byte[6:0] != 7'd0)
				ev.kind <= kind_note_on;
			else
				ev.kind <= kind_note_off;  // Includes Note On at velocity 0
		end
	end

	a_kind_known: assert property (@(posedge MHz10) disable iff (!nrst)
		ev.valid |-> !$isunknown(ev.kind) &&
			(ev.kind inside {kind_note_on, kind_note_off, kind_control}));

endmodule

// ==== hdl/synth_ifs.sv ====
/*
 * Internal buses of the synth core
 * midi_ev_if has no back-pressure, sinks take the event on the valid cycle
 * voice_if is a combinational read port into the voice registers
 */
`timescale 1ns/1ps

interface midi_ev_if;
	import synth_pkg::*;

	logic       valid;  // One-cycle pulse per event
	midi_kind_t kind;   // Held until the next event
	note_t      note;   // Note number, or controller number for kind_control
	vel_t       value;  // Velocity, or controller value

	modport source (
		output valid,
		output kind,
		output note,
		output value
	);

	modport sink (
		input valid,
		input kind,
		input note,
		input value
	);
endinterface

interface voice_if;
	import synth_pkg::*;

	voice_idx_t sel;
	logic       active;
	phase_t     phase;
	vel_t       vel;

	// Mixer picks a voice, bank answers in the same cycle
	modport mixer (
		output sel,
		input  active,
		input  phase,
		input  vel
	);

	modport bank (
		input  sel,
		output active,
		output phase,
		output vel
	);
endinterface

// ==== hdl/synth_pkg.sv ====
/*
 * Shared types of the synth core
 * phase_t follows SYNTH_PHASE_W, the mixer takes its top 8 bits as the wave position
 */
`include "synth_defs.svh"

package synth_pkg;

	// Cycled by the wave button in this order
	typedef enum logic [1:0] {
		wave_saw    = 2'd0,
		wave_square = 2'd1,
		wave_tri    = 2'd2
	} wave_mode_t;

	// Decoded MIDI event
	typedef enum logic [1:0] {
		kind_note_on  = 2'd0,
		kind_note_off = 2'd1,
		kind_control  = 2'd2
	} midi_kind_t;

	typedef logic [$clog2(`SYNTH_VOICES)-1:0] voice_idx_t;

	typedef logic [7:0] midi_byte_t;

	typedef logic [6:0] vel_t;

	typedef logic [6:0] note_t;

	typedef logic [`SYNTH_PHASE_W-1:0] phase_t;

endpackage

// ==== hdl/synth_defs.svh ====
/*
 * Build constants for the synth core, all counts assume a 10 MHz clock
 * Changing SYNTH_VOICES also changes the width of the voice index
 */
`ifndef SYNTH_DEFS_SVH
`define SYNTH_DEFS_SVH

// Voices sounding at once
`define SYNTH_VOICES 8

// 10 MHz / 31250 baud
`define SYNTH_BAUD_DIV 320

// 10 MHz / 40 kHz sample rate
`define SYNTH_SAMPLE_DIV 250

// 2 ms of stable button level
`define SYNTH_DEBOUNCE 20000

`define SYNTH_PHASE_W 20

`endif
